/* Makefile */
TOP := tb_camera_grabber

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

/* burst_writer.sv */
`include "camera_defines.svh"

module burst_writer
  import camera_pkg::*;
(
  input  logic         clock,
  input  logic         arst_n,
  input  frame_event_t events,
  input  logic         capture_enable,
  input  word_t        frame_base,
  input  word_idx_t    words_per_line,
  output word_idx_t    rd_addr,
  input  word_t        rd_data,
  output logic         request_bus,
  input  logic         bus_grant,
  input  logic         busy,
  input  logic         bus_error,
  output bus_out_t     bus
);

  wr_state_e state_q;
  wr_state_e state_d;
  word_t     addr_q;
  word_t     data_q;
  word_t     dropped;
  word_idx_t words_left_q;
  word_idx_t burst_left_q;
  word_idx_t burst_len;
  word_idx_t rd_idx_q;
  logic      data_valid_q;
  logic      load;
  logic      accept;

  // ====================
  // Datapath control
  // ====================

  assign burst_len = (words_left_q > word_idx_t'(`CAM_MAX_BURST)) ?
                     word_idx_t'(`CAM_MAX_BURST) : words_left_q;

  // A new word goes out when the bus is free. The presented word is taken on the same edge.
  assign load   = (state_q == BURST) && !bus_error && !busy && (burst_left_q != '0);
  assign accept = (state_q == BURST) && !bus_error && !busy && data_valid_q;

  // The read address runs one word ahead so rd_data is ready for the next load.
  assign rd_addr = load ? rd_idx_q + 1'b1 : rd_idx_q;

  // Words of the line that never reach memory after a bus error.
  assign dropped     = word_t'(words_left_q) + word_t'(burst_left_q) + word_t'(data_valid_q);
  assign request_bus = (state_q == REQUEST);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
        if (events.line_end && capture_enable && (words_per_line != '0))
          state_d = REQUEST;
      REQUEST:
        if (bus_grant)
          state_d = INIT;
      INIT:
        state_d = BURST;
      BURST:
        if (bus_error || (!busy && (burst_left_q == '0)))
          state_d = END;
      END:
        state_d = (words_left_q != '0) ? REQUEST : IDLE;
      default:
        state_d = IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q      <= IDLE;
      addr_q       <= '0;
      words_left_q <= '0;
      burst_left_q <= '0;
      rd_idx_q     <= '0;
      data_valid_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if ((state_q == IDLE) && (state_d == REQUEST))
      begin
        words_left_q <= words_per_line;
        rd_idx_q     <= '0;
      end
      if (state_q == INIT)
      begin
        words_left_q <= words_left_q - burst_len;
        burst_left_q <= burst_len;
      end
      if (load)
      begin
        rd_idx_q     <= rd_idx_q + 1'b1;
        burst_left_q <= burst_left_q - 1'b1;
      end
      if ((state_q == BURST) && (bus_error || !busy))
        data_valid_q <= load;

      // On an error the address skips the dropped words so the next line lands in place.
      if (events.frame_start)
        addr_q <= frame_base;
      else if (accept)
        addr_q <= addr_q + 32'd4;
      else if ((state_q == BURST) && bus_error)
      begin
        addr_q       <= addr_q + (dropped << 2);
        words_left_q <= '0;
        burst_left_q <= '0;
      end
    end
  end

  always_ff @(posedge clock)
  begin
    if (load)
      data_q <= rd_data;
  end

  // ====================
  // Bus outputs
  // ====================

  always_comb
  begin
    bus                   = '0;
    bus.begin_transaction = (state_q == INIT);
    bus.end_transaction   = (state_q == END);
    bus.data_valid        = data_valid_q;
    if (data_valid_q)
      bus.address_data = data_q;
    if (state_q == INIT)
    begin
      bus.byte_enables = 4'hF;
      bus.burst_size   = 8'(burst_len - 1'b1);
      bus.address_data = addr_q;
    end
  end

endmodule

/* camera_assertions.sv */
module camera_assertions
  import camera_pkg::*;
(
  input logic     clock,
  input logic     arst_n,
  input logic     busy,
  input logic     bus_error,
  input bus_out_t bus
);

  logic in_transaction;
  int   failures = 0;

  // A transaction is open from begin_transaction until end_transaction.
  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
      in_transaction <= 1'b0;
    else if (bus.begin_transaction)
      in_transaction <= 1'b1;
    else if (bus.end_transaction)
      in_transaction <= 1'b0;
  end

  // Data words only appear inside a burst.
  data_in_transaction: assert property (@(posedge clock) disable iff (!arst_n)
    bus.data_valid |-> in_transaction)
    else
    begin
      $error("data_valid seen outside a transaction");
      failures++;
    end

  begin_one_cycle: assert property (@(posedge clock) disable iff (!arst_n)
    bus.begin_transaction |=> !bus.begin_transaction)
    else
    begin
      $error("begin_transaction longer than one cycle");
      failures++;
    end

  // A stalled word stays on the bus until it is taken.
  hold_while_busy: assert property (@(posedge clock) disable iff (!arst_n)
    (bus.data_valid && busy && !bus_error) |=> (bus.data_valid && $stable(bus.address_data)))
    else
    begin
      $error("address_data changed while busy");
      failures++;
    end

endmodule

bind burst_writer camera_assertions u_camera_assertions (
  .clock     (clock),
  .arst_n    (arst_n),
  .busy      (busy),
  .bus_error (bus_error),
  .bus       (bus)
);

/* camera_defines.svh */
`ifndef CAMERA_DEFINES_SVH
`define CAMERA_DEFINES_SVH

// ====================
// Custom-instruction decode
// ====================

// Instruction number that selects the frame grabber.
`define CAM_CI_ID 8'h2A

// ====================
// Bus and counter sizes
// ====================

// Longest burst the writer issues, in 32-bit words.
`define CAM_MAX_BURST 16

// Counter widths for bytes per line, lines per frame and line-buffer words.
`define CAM_BYTE_CNT_W 12
`define CAM_LINE_CNT_W 11
`define CAM_WORD_IDX_W 9

`endif

/* camera_grabber_top.sv */
`include "camera_defines.svh"

module camera_grabber_top
  import camera_pkg::*;
(
  input  logic       clock,
  input  logic       arst_n,
  input  logic       hsync,
  input  logic       vsync,
  input  gray_t      cam_data,
  input  logic       ci_start,
  input  logic       ci_cke,
  input  logic [7:0] ci_n,
  input  word_t      ci_value_a,
  input  word_t      ci_value_b,
  output word_t      ci_result,
  output logic       ci_done,
  output logic       request_bus,
  input  logic       bus_grant,
  input  logic       busy,
  input  logic       bus_error,
  output logic       begin_transaction,
  output logic       end_transaction,
  output logic [3:0] byte_enables,
  output logic [7:0] burst_size,
  output logic       data_valid,
  output word_t      address_data
);

  frame_event_t events;
  byte_cnt_t    byte_count;
  byte_cnt_t    bytes_per_line;
  word_idx_t    words_per_line;
  line_cnt_t    lines_per_frame;
  logic         wr_en;
  word_idx_t    wr_addr;
  word_t        wr_data;
  word_idx_t    rd_addr;
  word_t        rd_data;
  word_t        frame_base;
  logic         capture_enable;
  ci_req_t      ci_req;
  bus_out_t     bus;

  // ====================
  // Port mapping
  // ====================

  assign ci_req.sel     = ci_start & ci_cke & (ci_n == `CAM_CI_ID);
  assign ci_req.cmd     = ci_cmd_e'(ci_value_a[2:0]);
  assign ci_req.value_b = ci_value_b;
  assign ci_done        = ci_req.sel;

  assign begin_transaction = bus.begin_transaction;
  assign end_transaction   = bus.end_transaction;
  assign byte_enables      = bus.byte_enables;
  assign burst_size        = bus.burst_size;
  assign data_valid        = bus.data_valid;
  assign address_data      = bus.address_data;

  // ====================
  // Pipeline
  // ====================

  frame_timing u_frame_timing (
    .clock           (clock),
    .arst_n          (arst_n),
    .hsync           (hsync),
    .vsync           (vsync),
    .cam_data        (cam_data),
    .events          (events),
    .byte_count      (byte_count),
    .bytes_per_line  (bytes_per_line),
    .words_per_line  (words_per_line),
    .lines_per_frame (lines_per_frame)
  );

  pixel_packer u_pixel_packer (
    .clock      (clock),
    .arst_n     (arst_n),
    .hsync      (hsync),
    .cam_data   (cam_data),
    .byte_count (byte_count),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data)
  );

  line_buffer u_line_buffer (
    .clock   (clock),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .rd_addr (rd_addr),
    .wr_data (wr_data),
    .rd_data (rd_data)
  );

  ci_regs u_ci_regs (
    .clock           (clock),
    .arst_n          (arst_n),
    .ci              (ci_req),
    .events          (events),
    .bytes_per_line  (bytes_per_line),
    .lines_per_frame (lines_per_frame),
    .result          (ci_result),
    .frame_base      (frame_base),
    .capture_enable  (capture_enable)
  );

  burst_writer u_burst_writer (
    .clock          (clock),
    .arst_n         (arst_n),
    .events         (events),
    .capture_enable (capture_enable),
    .frame_base     (frame_base),
    .words_per_line (words_per_line),
    .rd_addr        (rd_addr),
    .rd_data        (rd_data),
    .request_bus    (request_bus),
    .bus_grant      (bus_grant),
    .busy           (busy),
    .bus_error      (bus_error),
    .bus            (bus)
  );

endmodule

/* camera_pkg.sv */
`include "camera_defines.svh"

package camera_pkg;

  typedef logic [31:0] word_t;
  typedef logic [7:0] gray_t;
  typedef logic [`CAM_BYTE_CNT_W-1:0] byte_cnt_t;
  typedef logic [`CAM_LINE_CNT_W-1:0] line_cnt_t;
  typedef logic [`CAM_WORD_IDX_W-1:0] word_idx_t;

  // Commands carried in the low three bits of the A operand.
  typedef enum logic [2:0] {
    CMD_BYTES_PER_LINE = 3'd0,
    CMD_LINES          = 3'd1,
    CMD_READ_BASE      = 3'd4,
    CMD_WRITE_BASE     = 3'd5,
    CMD_CONTROL        = 3'd6,
    CMD_SHOT_DONE      = 3'd7
  } ci_cmd_e;

  typedef struct packed {
    logic    sel;
    ci_cmd_e cmd;
    word_t   value_b;
  } ci_req_t;

  typedef struct packed {
    logic line_end;
    logic frame_start;
  } frame_event_t;

  typedef struct packed {
    logic       begin_transaction;
    logic       end_transaction;
    logic [3:0] byte_enables;
    logic [7:0] burst_size;
    logic       data_valid;
    word_t      address_data;
  } bus_out_t;

  typedef enum logic [2:0] {IDLE, REQUEST, INIT, BURST, END} wr_state_e;

  // Luma weights 77, 150 and 29 sum to 256, so the top byte is the gray value.
  function automatic gray_t rgb565_to_gray(gray_t high, gray_t low);
    logic [15:0] red;
    logic [15:0] green;
    logic [15:0] blue;
    logic [15:0] sum;
    red   = {8'd0, high[7:3], 3'b000};
    green = {8'd0, high[2:0], low[7:5], 2'b00};
    blue  = {8'd0, low[4:0], 3'b000};
    sum   = 16'd77 * red + 16'd150 * green + 16'd29 * blue;
    return sum[15:8];
  endfunction

endpackage

/* ci_regs.sv */
module ci_regs
  import camera_pkg::*;
(
  input  logic         clock,
  input  logic         arst_n,
  input  ci_req_t      ci,
  input  frame_event_t events,
  input  byte_cnt_t    bytes_per_line,
  input  line_cnt_t    lines_per_frame,
  output word_t        result,
  output word_t        frame_base,
  output logic         capture_enable
);

  word_t frame_base_q;
  logic  run_q;
  logic  run_active_q;
  logic  shot_armed_q;
  logic  shot_active_q;
  logic  shot_done_q;
  logic  is_control;

  assign is_control     = ci.sel && (ci.cmd == CMD_CONTROL);
  assign frame_base     = frame_base_q;
  assign capture_enable = run_active_q | shot_active_q;

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      frame_base_q  <= '0;
      run_q         <= 1'b0;
      run_active_q  <= 1'b0;
      shot_armed_q  <= 1'b0;
      shot_active_q <= 1'b0;
      shot_done_q   <= 1'b0;
    end
    else
    begin
      if (ci.sel && (ci.cmd == CMD_WRITE_BASE))
        frame_base_q <= {ci.value_b[31:2], 2'b00};
      if (is_control)
        run_q <= (ci.value_b[1:0] == 2'b01);

      // Mode changes wait for a frame boundary. An active shot ends at the next one.
      if (events.frame_start)
      begin
        run_active_q <= run_q;
        if (shot_active_q)
        begin
          shot_active_q <= 1'b0;
          shot_done_q   <= 1'b1;
        end
        else if (shot_armed_q)
        begin
          shot_active_q <= 1'b1;
          shot_armed_q  <= 1'b0;
        end
      end

      if (is_control && (ci.value_b[1:0] == 2'b10))
      begin
        shot_armed_q <= 1'b1;
        shot_done_q  <= 1'b0;
      end
    end
  end

  always_comb
  begin
    result = '0;
    if (ci.sel)
    begin
      case (ci.cmd)
        CMD_BYTES_PER_LINE: result = word_t'(bytes_per_line);
        CMD_LINES:          result = word_t'(lines_per_frame);
        CMD_READ_BASE:      result = frame_base_q;
        CMD_SHOT_DONE:      result = word_t'(shot_done_q);
        default:            result = '0;
      endcase
    end
  end

endmodule

/* frame_timing.sv */
`include "camera_defines.svh"

module frame_timing
  import camera_pkg::*;
(
  input  logic         clock,
  input  logic         arst_n,
  input  logic         hsync,
  input  logic         vsync,
  input  gray_t        cam_data,
  output frame_event_t events,
  output byte_cnt_t    byte_count,
  output byte_cnt_t    bytes_per_line,
  output word_idx_t    words_per_line,
  output line_cnt_t    lines_per_frame
);

  logic [1:0] hsync_q;
  logic [1:0] vsync_q;
  logic       hsync_fall;
  logic       vsync_fall;
  line_cnt_t  line_count;

  // Edges are seen one cycle after the sync is first sampled low.
  assign hsync_fall = hsync_q[1] & ~hsync_q[0];
  assign vsync_fall = vsync_q[1] & ~vsync_q[0];

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      hsync_q         <= '0;
      vsync_q         <= '0;
      events          <= '0;
      byte_count      <= '0;
      bytes_per_line  <= '0;
      words_per_line  <= '0;
      line_count      <= '0;
      lines_per_frame <= '0;
    end
    else
    begin
      hsync_q            <= {hsync_q[0], hsync};
      vsync_q            <= {vsync_q[0], vsync};
      events.line_end    <= hsync_fall;
      events.frame_start <= vsync_fall;

      // The held sizes change on the same edge as the event pulse.
      if (hsync_fall)
      begin
        bytes_per_line <= byte_count;
        words_per_line <= byte_count[`CAM_BYTE_CNT_W-1:3];
        byte_count     <= '0;
      end
      else if (hsync)
        byte_count <= byte_count + 1'b1;

      if (vsync_fall)
      begin
        lines_per_frame <= line_count;
        line_count      <= '0;
      end
      else if (hsync_fall)
        line_count <= line_count + 1'b1;
    end
  end

endmodule

/* line_buffer.sv */
`include "camera_defines.svh"

module line_buffer
  import camera_pkg::*;
(
  input  logic      clock,
  input  logic      wr_en,
  input  word_idx_t wr_addr,
  input  word_idx_t rd_addr,
  input  word_t     wr_data,
  output word_t     rd_data
);

  localparam int DEPTH = 2 ** `CAM_WORD_IDX_W;

  word_t mem [DEPTH];

  // Read data appears one cycle after the address.
  always_ff @(posedge clock)
  begin
    if (wr_en)
      mem[wr_addr] <= wr_data;
    rd_data <= mem[rd_addr];
  end

endmodule

/* pixel_packer.sv */
`include "camera_defines.svh"

module pixel_packer
  import camera_pkg::*;
(
  input  logic      clock,
  input  logic      arst_n,
  input  logic      hsync,
  input  gray_t     cam_data,
  input  byte_cnt_t byte_count,
  output logic      wr_en,
  output word_idx_t wr_addr,
  output word_t     wr_data
);

  gray_t      byte_q [0:6];
  logic [2:0] position;
  logic       last_byte;
  word_t      gray_word;

  assign position  = byte_count[2:0];
  assign last_byte = hsync && (position == 3'd7);

  // Pixel k of the group sits in bits 8k+7 to 8k. The eighth byte is still on the port.
  assign gray_word = {rgb565_to_gray(byte_q[6], cam_data),
                      rgb565_to_gray(byte_q[4], byte_q[5]),
                      rgb565_to_gray(byte_q[2], byte_q[3]),
                      rgb565_to_gray(byte_q[0], byte_q[1])};

  always_ff @(posedge clock)
  begin
    if (hsync && (position != 3'd7))
      byte_q[position] <= cam_data;
    if (last_byte)
    begin
      wr_addr <= byte_count[`CAM_BYTE_CNT_W-1:3];
      wr_data <= gray_word;
    end
  end

  // One write strobe per group of eight bytes, a cycle after the last byte.
  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
      wr_en <= 1'b0;
    else
      wr_en <= last_byte;
  end

endmodule

/* sources.f */
+incdir+.
camera_pkg.sv
frame_timing.sv
pixel_packer.sv
line_buffer.sv
ci_regs.sv
burst_writer.sv
camera_grabber_top.sv
camera_assertions.sv
tb_clock_gen.sv
tb_camera_grabber.sv

/* tb_camera_grabber.sv */
`include "camera_defines.svh"

module tb_camera_grabber
  import camera_pkg::*;
;

  typedef struct packed {
    int          kind;
    int          cmd;
    logic [31:0] operand;
    int          lines;
    int          bytes;
    logic [31:0] expected;
    int          err_line;
  } step_t;

  localparam int KIND_CI = 0;
  localparam int KIND_FRAME = 1;
  localparam int KIND_IDLE_FRAME = 2;

  logic clock, arst_n, hsync, vsync, ci_start, ci_cke, ci_done, request_bus;
  logic bus_grant, busy, bus_error, begin_transaction, end_transaction, data_valid;
  logic [7:0] cam_data, ci_n, burst_size;
  logic [3:0] byte_enables;
  word_t ci_value_a, ci_value_b, ci_result, address_data;

  step_t steps[$];
  word_t mem[word_t];
  logic [7:0] pix [0:4095];
  integer seed = 84377;
  word_t cur_base = '0;
  word_t slave_addr = '0;
  int write_count = 0;
  int ends_after_error = 0;
  logic err_pending = 1'b0;
  logic error_seen = 1'b0;
  int line_words = 0;
  int words_pending = 0;
  int burst_words = 0;
  logic in_burst = 1'b0;

  tb_clock_gen u_clock_gen (.clock(clock), .arst_n(arst_n));

  camera_grabber_top u_dut (.*);

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("[ERROR] t=%0t %s expected 0x%08h actual 0x%08h", $time, name, expected, actual);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  function automatic logic [7:0] expected_gray(input logic [7:0] hi, input logic [7:0] lo);
    int r;
    int g;
    int b;
    r = int'(hi[7:3]) * 8;
    g = int'({hi[2:0], lo[7:5]}) * 4;
    b = int'(lo[4:0]) * 8;
    return 8'((77 * r + 150 * g + 29 * b) / 256);
  endfunction

  function automatic int gap_cycles(input int bytes);
    return 4 * (bytes / 8) + 40;
  endfunction

  function automatic int step_cycles(input step_t s);
    if (s.kind == KIND_CI)
      return 2;
    return 16 + s.lines * (s.bytes + 1 + gap_cycles(s.bytes));
  endfunction

  task automatic add_step(input int kind, input int cmd, input logic [31:0] operand,
                          input int lines, input int bytes, input logic [31:0] expected,
                          input int err_line);
    step_t s;
    s = '{kind, cmd, operand, lines, bytes, expected, err_line};
    steps.push_back(s);
  endtask

  // ====================
  // Bus slave model
  // ====================

  // New inputs are chosen on the falling edge, so a word is taken on the next rising edge.
  always @(negedge clock)
  begin
    if (arst_n)
    begin
      bus_grant = request_bus && ({$random(seed)} % 3 == 0);
      busy      = ({$random(seed)} % 4 == 0);
      bus_error = 1'b0;
      if (err_pending && data_valid)
      begin
        bus_error     = 1'b1;
        busy          = 1'b0;
        err_pending   = 1'b0;
        error_seen    = 1'b1;
        words_pending = 0;
      end
      if (begin_transaction)
      begin
        check_value("open burst at begin_transaction", 0, 32'(in_burst));
        slave_addr = address_data;
        // A line is split into bursts of at most the maximum length.
        if (words_pending == 0)
          words_pending = line_words;
        burst_words   = (words_pending > `CAM_MAX_BURST) ? `CAM_MAX_BURST : words_pending;
        words_pending = words_pending - burst_words;
        in_burst      = 1'b1;
        check_value("byte_enables", 32'hF, 32'(byte_enables));
        check_value("burst_size", 32'(burst_words - 1), 32'(burst_size));
      end
      if (end_transaction)
      begin
        check_value("open burst at end_transaction", 1, 32'(in_burst));
        if (error_seen)
          ends_after_error++;
        else
          check_value("words left at end_transaction", 0, 32'(burst_words));
        error_seen = 1'b0;
        in_burst   = 1'b0;
      end
      if (data_valid && !busy && !bus_error)
      begin
        mem[slave_addr] = address_data;
        slave_addr      = slave_addr + 32'd4;
        burst_words--;
        write_count++;
      end
    end
  end

  // ====================
  // Camera and instruction drivers
  // ====================

  task automatic pulse_vsync();
    @(negedge clock);
    vsync = 1'b1;
    repeat (3) @(negedge clock);
    vsync = 1'b0;
    repeat (4) @(negedge clock);
  endtask

  task automatic send_frame(input step_t s);
    int l;
    int i;
    line_words = s.bytes / 8;
    pulse_vsync();
    for (l = 0; l < s.lines; l++)
    begin
      if (l == s.err_line)
        err_pending = 1'b1;
      for (i = 0; i < s.bytes; i++)
      begin
        @(negedge clock);
        hsync    = 1'b1;
        cam_data = 8'($random(seed));
        pix[l * s.bytes + i] = cam_data;
      end
      @(negedge clock);
      hsync = 1'b0;
      repeat (gap_cycles(s.bytes)) @(negedge clock);
    end
    pulse_vsync();
  endtask

  task automatic check_frame(input step_t s);
    int l;
    int w;
    int p;
    word_t addr;
    word_t expected;
    for (l = 0; l < s.lines; l++)
    begin
      for (w = 0; w < s.bytes / 8; w++)
      begin
        p        = l * s.bytes + 8 * w;
        addr     = cur_base + 32'(4 * (l * (s.bytes / 8) + w));
        expected = {expected_gray(pix[p + 6], pix[p + 7]), expected_gray(pix[p + 4], pix[p + 5]),
                    expected_gray(pix[p + 2], pix[p + 3]), expected_gray(pix[p], pix[p + 1])};
        if (l != s.err_line)
          check_value($sformatf("mem[0x%08h]", addr), expected,
                      mem.exists(addr) ? mem[addr] : 32'hxxxxxxxx);
      end
    end
  endtask

  task automatic run_ci(input step_t s);
    @(negedge clock);
    ci_start   = 1'b1;
    ci_cke     = 1'b1;
    ci_n       = `CAM_CI_ID;
    ci_value_a = 32'(s.cmd);
    ci_value_b = s.operand;
    #1;
    check_value("ci_done", 32'd1, 32'(ci_done));
    check_value("ci_result", s.expected, ci_result);
    if (s.cmd == int'(CMD_WRITE_BASE))
      cur_base = s.operand & 32'hFFFF_FFFC;
    @(negedge clock);
    ci_start = 1'b0;
    ci_cke   = 1'b0;
  endtask

  initial
  begin
    int k;
    int writes_before;
    {hsync, vsync, cam_data, ci_start, ci_cke, ci_n} = '0;
    {ci_value_a, ci_value_b, bus_grant, busy, bus_error} = '0;

    add_step(KIND_CI, CMD_WRITE_BASE, 32'h1003, 0, 0, 0, -1);
    add_step(KIND_CI, CMD_READ_BASE, 0, 0, 0, 32'h1000, -1);
    add_step(KIND_CI, CMD_CONTROL, 1, 0, 0, 0, -1);
    add_step(KIND_FRAME, 0, 0, 3, 16, 0, -1);
    add_step(KIND_CI, CMD_BYTES_PER_LINE, 0, 0, 0, 16, -1);
    add_step(KIND_CI, CMD_LINES, 0, 0, 0, 3, -1);
    add_step(KIND_CI, CMD_WRITE_BASE, 32'h2000, 0, 0, 0, -1);
    add_step(KIND_FRAME, 0, 0, 2, 160, 0, -1);
    add_step(KIND_CI, CMD_BYTES_PER_LINE, 0, 0, 0, 160, -1);
    add_step(KIND_CI, CMD_WRITE_BASE, 32'h3000, 0, 0, 0, -1);
    add_step(KIND_FRAME, 0, 0, 3, 64, 0, 1);
    add_step(KIND_CI, CMD_CONTROL, 2, 0, 0, 0, -1);
    add_step(KIND_CI, CMD_SHOT_DONE, 0, 0, 0, 0, -1);
    add_step(KIND_CI, CMD_WRITE_BASE, 32'h4000, 0, 0, 0, -1);
    add_step(KIND_FRAME, 0, 0, 2, 32, 0, -1);
    add_step(KIND_CI, CMD_SHOT_DONE, 0, 0, 0, 1, -1);
    add_step(KIND_CI, CMD_WRITE_BASE, 32'h5000, 0, 0, 0, -1);
    add_step(KIND_IDLE_FRAME, 0, 0, 2, 32, 0, -1);

    @(posedge arst_n);
    @(negedge clock);
    #1;
    check_value("request_bus", 0, 32'(request_bus));
    check_value("begin_transaction", 0, 32'(begin_transaction));
    check_value("end_transaction", 0, 32'(end_transaction));
    check_value("data_valid", 0, 32'(data_valid));
    check_value("byte_enables", 0, 32'(byte_enables));
    check_value("burst_size", 0, 32'(burst_size));
    check_value("ci_done", 0, 32'(ci_done));
    check_value("ci_result", 0, ci_result);

    // An instruction for another unit is ignored.
    @(negedge clock);
    {ci_start, ci_cke, ci_n, ci_value_a} = {2'b11, 8'(`CAM_CI_ID + 1), 32'd4};
    #1;
    check_value("ci_done", 0, 32'(ci_done));
    check_value("ci_result", 0, ci_result);
    @(negedge clock);
    {ci_start, ci_cke} = 2'b00;

    for (k = 0; k < steps.size(); k++)
    begin
      writes_before    = write_count;
      ends_after_error = 0;
      if (steps[k].kind == KIND_CI)
        run_ci(steps[k]);
      else
        send_frame(steps[k]);
      if (steps[k].kind == KIND_FRAME)
        check_frame(steps[k]);
      if (steps[k].kind == KIND_IDLE_FRAME)
        check_value("bus write count", 32'(writes_before), 32'(write_count));
      if (steps[k].err_line >= 0)
        check_value("end_transaction after bus_error", 1, 32'(ends_after_error));
    end

    $display("Simulation PASSED");
    $finish;
  end

  // Watchdog sized from the table, twice the expected run time.
  initial
  begin
    longint limit;
    int j;
    #1;
    limit = 0;
    for (j = 0; j < steps.size(); j++)
      limit = limit + step_cycles(steps[j]);
    limit = limit * 2 * 4 + 200;
    #(limit);
    $display("Timeout: the tests did not finish within %0d time units.", limit);
    $display("Simulation FAILED");
    $fatal(1);
  end

  // A failed bus protocol assertion ends the run.
  initial
  begin
    wait (u_dut.u_burst_writer.u_camera_assertions.failures != 0);
    $display("A bus protocol assertion failed.");
    $display("Simulation FAILED");
    $fatal(1);
  end

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen (
  output logic clock,
  output logic arst_n
);

  initial
  begin
    clock  = 1'b0;
    arst_n = 1'b0;
    forever #2 clock = ~clock;
  end

  // Reset is held for five rising edges and released on a falling edge.
  initial
  begin
    repeat (5) @(posedge clock);
    @(negedge clock);
    arst_n = 1'b1;
  end

endmodule
